// File: src/lidar_angle_params.svh
`ifndef LIDAR_ANGLE_PARAMS_SVH
`define LIDAR_ANGLE_PARAMS_SVH

// AXI4-Lite bus geometry
`define LA_ADDR_W        5
`define LA_DATA_W        32

`define LA_ANGLE_W       16   // Angle and offset width in ticks

`define LA_RESO_DEFAULT  10   // Ticks per degree out of reset

`endif

// File: src/lidar_angle_pkg.sv
`include "lidar_angle_params.svh"

package lidar_angle_pkg;

	// Angular resolution selected by software
	typedef enum logic [3:0] {
		RESO_0P1  = 4'd0,   // 0.1 degree, 10 ticks per degree
		RESO_0P05 = 4'd1,   // 0.05 degree, 20 ticks per degree
		RESO_0P2  = 4'd2,   // 0.2 degree, 5 ticks per degree
		RESO_0P33 = 4'd3    // About 1/3 degree, 3 ticks per degree
	} reso_mode_e;

	typedef logic [`LA_ANGLE_W-1:0] angle_tick_t;

endpackage

// File: src/lidar_axil_pkg.sv
`include "lidar_angle_params.svh"

package lidar_axil_pkg;

	typedef enum logic [`LA_ADDR_W-1:0] {
		REG_RESO      = 5'h00,
		REG_ZERO_OFS  = 5'h04,
		REG_ANGLE_OFS = 5'h08,
		REG_ANGLE     = 5'h0C,   // Read only
		REG_REVS      = 5'h10    // Read only
	} reg_addr_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

endpackage

// File: src/axil_cfg_regs.sv
`timescale 1ns/1ps
`include "lidar_angle_params.svh"

module axil_cfg_regs (
	input  logic                       i_clk_50m,
	input  logic                       i_rst_n,
	input  logic [`LA_ADDR_W-1:0]      i_s_awaddr,
	input  logic                       i_s_awvalid,
	output logic                       o_s_awready,
	input  logic [`LA_DATA_W-1:0]      i_s_wdata,
	input  logic [`LA_DATA_W/8-1:0]    i_s_wstrb,
	input  logic                       i_s_wvalid,
	output logic                       o_s_wready,
	output logic                       o_s_bvalid,
	output lidar_axil_pkg::axil_resp_e o_s_bresp,
	input  logic                       i_s_bready,
	input  logic [`LA_ADDR_W-1:0]      i_s_araddr,
	input  logic                       i_s_arvalid,
	output logic                       o_s_arready,
	output logic                       o_s_rvalid,
	output logic [`LA_DATA_W-1:0]      o_s_rdata,
	output lidar_axil_pkg::axil_resp_e o_s_rresp,
	input  logic                       i_s_rready,
	input  logic [`LA_ANGLE_W-1:0]     i_angle,
	input  logic [15:0]                i_rev_count,
	output logic [3:0]                 o_reso_mode,
	output logic [`LA_ANGLE_W-1:0]     o_zero_offset,
	output logic [`LA_ANGLE_W-1:0]     o_angle_offset
);
	import lidar_axil_pkg::*;

	logic                    r_wr_ready;
	logic                    r_bvalid;
	axil_resp_e              r_bresp;
	logic                    r_arready;
	logic                    r_rvalid;
	axil_resp_e              r_rresp;
	logic [`LA_DATA_W-1:0]   r_rdata;
	logic [3:0]              r_reso;
	logic [`LA_ANGLE_W-1:0]  r_zero_ofs;
	logic [`LA_ANGLE_W-1:0]  r_angle_ofs;
	logic                    w_wr_hs;
	logic                    w_rd_hs;
	reg_addr_e               w_wr_addr;
	reg_addr_e               w_rd_addr;
	axil_resp_e              w_wr_resp;
	axil_resp_e              w_rd_resp;
	logic [`LA_DATA_W-1:0]   w_rd_data;

	function automatic logic [15:0] merge16(input logic [15:0] old_val,
		input logic [15:0] new_val, input logic [1:0] strb);
		logic [15:0] v;
		v = old_val;
		if (strb[0])
			v[7:0] = new_val[7:0];
		if (strb[1])
			v[15:8] = new_val[15:8];
		return v;
	endfunction

	assign w_wr_addr = reg_addr_e'(i_s_awaddr);
	assign w_rd_addr = reg_addr_e'(i_s_araddr);
	assign w_wr_hs   = r_wr_ready & i_s_awvalid & i_s_wvalid;
	assign w_rd_hs   = r_arready & i_s_arvalid;

	// Only the three configuration registers accept writes
	always_comb begin
		case (w_wr_addr)
			REG_RESO, REG_ZERO_OFS, REG_ANGLE_OFS: w_wr_resp = OKAY;
			default:                               w_wr_resp = SLVERR;
		endcase
	end

	always_comb begin
		w_rd_data = '0;
		w_rd_resp = OKAY;
		case (w_rd_addr)
			REG_RESO:      w_rd_data = `LA_DATA_W'(r_reso);
			REG_ZERO_OFS:  w_rd_data = `LA_DATA_W'(r_zero_ofs);
			REG_ANGLE_OFS: w_rd_data = `LA_DATA_W'(r_angle_ofs);
			REG_ANGLE:     w_rd_data = `LA_DATA_W'(i_angle);
			REG_REVS:      w_rd_data = `LA_DATA_W'(i_rev_count);
			default:       w_rd_resp = SLVERR;
		endcase
	end

	// AW and W accepted together, one cycle pulse
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_wr_ready <= 1'b0;
			r_bvalid   <= 1'b0;
			r_bresp    <= OKAY;
		end else begin
			r_wr_ready <= ~r_wr_ready & i_s_awvalid & i_s_wvalid & ~r_bvalid;
			if (w_wr_hs) begin
				r_bvalid <= 1'b1;
				r_bresp  <= w_wr_resp;
			end else if (i_s_bready) begin
				r_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_reso      <= '0;
			r_zero_ofs  <= '0;
			r_angle_ofs <= '0;
		end else if (w_wr_hs) begin
			case (w_wr_addr)
				REG_RESO: begin
					if (i_s_wstrb[0])
						r_reso <= i_s_wdata[3:0];
				end
				REG_ZERO_OFS:  r_zero_ofs  <= merge16(r_zero_ofs, i_s_wdata[15:0], i_s_wstrb[1:0]);
				REG_ANGLE_OFS: r_angle_ofs <= merge16(r_angle_ofs, i_s_wdata[15:0], i_s_wstrb[1:0]);
				default: ;   // Read-only or unmapped, nothing changes
			endcase
		end
	end

	// Read channel, arready drops while a response waits
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_arready <= 1'b0;
			r_rvalid  <= 1'b0;
			r_rresp   <= OKAY;
		end else begin
			r_arready <= ~(w_rd_hs | (r_rvalid & ~i_s_rready));
			if (w_rd_hs) begin
				r_rvalid <= 1'b1;
				r_rresp  <= w_rd_resp;
			end else if (i_s_rready) begin
				r_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (w_rd_hs)
			r_rdata <= w_rd_data;
	end

	assign o_s_awready    = r_wr_ready;
	assign o_s_wready     = r_wr_ready;
	assign o_s_bvalid     = r_bvalid;
	assign o_s_bresp      = r_bresp;
	assign o_s_arready    = r_arready;
	assign o_s_rvalid     = r_rvalid;
	assign o_s_rdata      = r_rdata;
	assign o_s_rresp      = r_rresp;
	assign o_reso_mode    = r_reso;
	assign o_zero_offset  = r_zero_ofs;
	assign o_angle_offset = r_angle_ofs;

endmodule

// File: src/measure_para.sv
`timescale 1ns/1ps
`include "lidar_angle_params.svh"

module measure_para (
	input  logic                         i_clk_50m,
	input  logic                         i_rst_n,
	input  logic [3:0]                   i_reso_mode,
	input  logic [`LA_ANGLE_W-1:0]       i_zero_offset,
	input  logic [`LA_ANGLE_W-1:0]       i_angle_offset,
	output lidar_angle_pkg::angle_tick_t o_zero_ticks,
	output lidar_angle_pkg::angle_tick_t o_angle_ticks,
	output lidar_angle_pkg::angle_tick_t o_rev_ticks
);
	import lidar_angle_pkg::*;

	reso_mode_e              r_mode;
	logic [`LA_ANGLE_W-1:0]  r_zero_ofs;
	logic [`LA_ANGLE_W-1:0]  r_angle_ofs;
	reso_mode_e              r_eff_mode;
	logic [7:0]              r_tpd;
	angle_tick_t             r_rev_len;
	angle_tick_t             r_zero_prod;
	angle_tick_t             r_angle_prod;
	angle_tick_t             r_rev_d3;
	angle_tick_t             r_zero_sum;
	angle_tick_t             r_angle_sum;
	angle_tick_t             r_rev_d4;
	reso_mode_e              w_eff_mode_nxt;
	logic [7:0]              w_tpd_nxt;

	function automatic angle_tick_t scale_frac(input logic [3:0] frac, input reso_mode_e mode);
		angle_tick_t v;
		case (mode)
			RESO_0P05: v = angle_tick_t'({frac, 1'b0});
			RESO_0P2:  v = angle_tick_t'(frac[3:1]);
			RESO_0P33: v = angle_tick_t'(frac[3:2]);   // Divide by 3.33 approximated as 4
			default:   v = angle_tick_t'(frac);
		endcase
		return v;
	endfunction

	// Modes 4 to 15 hold the last valid resolution
	always_comb begin
		w_eff_mode_nxt = r_mode;
		case (r_mode)
			RESO_0P1:  w_tpd_nxt = 8'd10;
			RESO_0P05: w_tpd_nxt = 8'd20;
			RESO_0P2:  w_tpd_nxt = 8'd5;
			RESO_0P33: w_tpd_nxt = 8'd3;
			default: begin
				w_tpd_nxt      = r_tpd;
				w_eff_mode_nxt = r_eff_mode;
			end
		endcase
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_mode       <= RESO_0P1;
			r_zero_ofs   <= '0;
			r_angle_ofs  <= '0;
			r_eff_mode   <= RESO_0P1;
			r_tpd        <= 8'(`LA_RESO_DEFAULT);
			r_rev_len    <= angle_tick_t'(360 * `LA_RESO_DEFAULT);
			r_zero_prod  <= '0;
			r_angle_prod <= '0;
			r_rev_d3     <= angle_tick_t'(360 * `LA_RESO_DEFAULT);
			r_zero_sum   <= '0;
			r_angle_sum  <= '0;
			r_rev_d4     <= angle_tick_t'(360 * `LA_RESO_DEFAULT);
		end else begin
			r_mode       <= reso_mode_e'(i_reso_mode);
			r_zero_ofs   <= i_zero_offset;
			r_angle_ofs  <= i_angle_offset;
			r_eff_mode   <= w_eff_mode_nxt;
			r_tpd        <= w_tpd_nxt;
			r_rev_len    <= angle_tick_t'(360 * w_tpd_nxt);
			r_zero_prod  <= angle_tick_t'(r_zero_ofs[15:4] * r_tpd);    // Whole degrees to ticks
			r_angle_prod <= angle_tick_t'(r_angle_ofs[15:4] * r_tpd);
			r_rev_d3     <= r_rev_len;
			r_zero_sum   <= r_zero_prod + scale_frac(r_zero_ofs[3:0], r_eff_mode);
			r_angle_sum  <= r_angle_prod + scale_frac(r_angle_ofs[3:0], r_eff_mode);
			r_rev_d4     <= r_rev_d3;   // Keeps the length aligned with the sums
		end
	end

	assign o_zero_ticks  = r_zero_sum;
	assign o_angle_ticks = r_angle_sum;
	assign o_rev_ticks   = r_rev_d4;

endmodule

// File: src/angle_tracker.sv
`timescale 1ns/1ps
`include "lidar_angle_params.svh"

module angle_tracker (
	input  logic                         i_clk_50m,
	input  logic                         i_rst_n,
	input  logic                         i_tdc_new_sig,
	input  lidar_angle_pkg::angle_tick_t i_zero_ticks,
	input  lidar_angle_pkg::angle_tick_t i_angle_ticks,
	input  lidar_angle_pkg::angle_tick_t i_rev_ticks,
	output lidar_angle_pkg::angle_tick_t o_angle,
	output logic                         o_zero_cross,
	output logic [15:0]                  o_rev_count
);
	import lidar_angle_pkg::*;

	angle_tick_t          r_count;
	angle_tick_t          r_rev_prev;
	angle_tick_t          r_angle;
	logic                 r_tick_d;
	logic                 r_zero_cross;
	logic [15:0]          r_rev_count;
	logic                 w_rev_change;
	angle_tick_t          w_zero_n;
	angle_tick_t          w_angle_n;
	angle_tick_t          w_corr;
	logic [`LA_ANGLE_W:0] w_sum;
	logic [`LA_ANGLE_W:0] w_diff;

	function automatic angle_tick_t fold_once(input angle_tick_t v, input angle_tick_t rev);
		angle_tick_t r;
		if (v >= rev)
			r = v - rev;
		else
			r = v;
		return r;
	endfunction

	assign w_rev_change = (i_rev_ticks != r_rev_prev);
	assign w_zero_n     = fold_once(i_zero_ticks, i_rev_ticks);
	assign w_angle_n    = fold_once(i_angle_ticks, i_rev_ticks);

	// count + angle - zero, wrapped into one revolution
	always_comb begin
		w_sum = {1'b0, r_count} + {1'b0, w_angle_n};
		if (w_sum >= {1'b0, w_zero_n})
			w_diff = w_sum - {1'b0, w_zero_n};
		else
			w_diff = w_sum + {1'b0, i_rev_ticks} - {1'b0, w_zero_n};
		if (w_diff >= {1'b0, i_rev_ticks})
			w_corr = angle_tick_t'(w_diff - {1'b0, i_rev_ticks});
		else
			w_corr = angle_tick_t'(w_diff);
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_count    <= '0;
			r_rev_prev <= angle_tick_t'(360 * `LA_RESO_DEFAULT);
			r_tick_d   <= 1'b0;
		end else begin
			r_rev_prev <= i_rev_ticks;
			if (w_rev_change) begin
				r_count  <= '0;   // New resolution restarts the revolution
				r_tick_d <= 1'b0;
			end else begin
				r_tick_d <= i_tdc_new_sig;
				if (i_tdc_new_sig) begin
					if (r_count >= angle_tick_t'(i_rev_ticks - 1'b1))
						r_count <= '0;
					else
						r_count <= r_count + 1'b1;
				end
			end
		end
	end

	// r_tick_d marks a count that just moved
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_angle      <= '0;
			r_zero_cross <= 1'b0;
			r_rev_count  <= '0;
		end else begin
			r_angle      <= w_corr;
			r_zero_cross <= r_tick_d && (w_corr == '0);
			if (w_rev_change)
				r_rev_count <= '0;
			else if (r_tick_d && (w_corr == '0))
				r_rev_count <= r_rev_count + 1'b1;
		end
	end

	assign o_angle      = r_angle;
	assign o_zero_cross = r_zero_cross;
	assign o_rev_count  = r_rev_count;

endmodule

// File: src/lidar_angle_top.sv
`timescale 1ns/1ps
`include "lidar_angle_params.svh"

module lidar_angle_top (
	input  logic                         i_clk_50m,
	input  logic                         i_rst_n,
	input  logic [`LA_ADDR_W-1:0]        i_s_awaddr,
	input  logic                         i_s_awvalid,
	output logic                         o_s_awready,
	input  logic [`LA_DATA_W-1:0]        i_s_wdata,
	input  logic [`LA_DATA_W/8-1:0]      i_s_wstrb,
	input  logic                         i_s_wvalid,
	output logic                         o_s_wready,
	output logic                         o_s_bvalid,
	output lidar_axil_pkg::axil_resp_e   o_s_bresp,
	input  logic                         i_s_bready,
	input  logic [`LA_ADDR_W-1:0]        i_s_araddr,
	input  logic                         i_s_arvalid,
	output logic                         o_s_arready,
	output logic                         o_s_rvalid,
	output logic [`LA_DATA_W-1:0]        o_s_rdata,
	output lidar_axil_pkg::axil_resp_e   o_s_rresp,
	input  logic                         i_s_rready,
	input  logic                         i_tdc_new_sig,
	output lidar_angle_pkg::angle_tick_t o_angle,
	output logic                         o_zero_cross
);
	import lidar_angle_pkg::*;

	logic [3:0]             w_reso_mode;
	logic [`LA_ANGLE_W-1:0] w_zero_offset;
	logic [`LA_ANGLE_W-1:0] w_angle_offset;
	angle_tick_t            w_zero_ticks;
	angle_tick_t            w_angle_ticks;
	angle_tick_t            w_rev_ticks;
	logic [15:0]            w_rev_count;

	axil_cfg_regs u_regs (
		.i_clk_50m      (i_clk_50m),
		.i_rst_n        (i_rst_n),
		.i_s_awaddr     (i_s_awaddr),
		.i_s_awvalid    (i_s_awvalid),
		.o_s_awready    (o_s_awready),
		.i_s_wdata      (i_s_wdata),
		.i_s_wstrb      (i_s_wstrb),
		.i_s_wvalid     (i_s_wvalid),
		.o_s_wready     (o_s_wready),
		.o_s_bvalid     (o_s_bvalid),
		.o_s_bresp      (o_s_bresp),
		.i_s_bready     (i_s_bready),
		.i_s_araddr     (i_s_araddr),
		.i_s_arvalid    (i_s_arvalid),
		.o_s_arready    (o_s_arready),
		.o_s_rvalid     (o_s_rvalid),
		.o_s_rdata      (o_s_rdata),
		.o_s_rresp      (o_s_rresp),
		.i_s_rready     (i_s_rready),
		.i_angle        (o_angle),        // Status readback
		.i_rev_count    (w_rev_count),
		.o_reso_mode    (w_reso_mode),
		.o_zero_offset  (w_zero_offset),
		.o_angle_offset (w_angle_offset)
	);

	measure_para u_para (
		.i_clk_50m      (i_clk_50m),
		.i_rst_n        (i_rst_n),
		.i_reso_mode    (w_reso_mode),
		.i_zero_offset  (w_zero_offset),
		.i_angle_offset (w_angle_offset),
		.o_zero_ticks   (w_zero_ticks),
		.o_angle_ticks  (w_angle_ticks),
		.o_rev_ticks    (w_rev_ticks)
	);

	angle_tracker u_tracker (
		.i_clk_50m      (i_clk_50m),
		.i_rst_n        (i_rst_n),
		.i_tdc_new_sig  (i_tdc_new_sig),
		.i_zero_ticks   (w_zero_ticks),
		.i_angle_ticks  (w_angle_ticks),
		.i_rev_ticks    (w_rev_ticks),
		.o_angle        (o_angle),
		.o_zero_cross   (o_zero_cross),
		.o_rev_count    (w_rev_count)
	);

endmodule

// File: sim/tb_lidar_angle.sv
`timescale 1ns/1ps
`include "lidar_angle_params.svh"

module tb_lidar_angle;
	import lidar_angle_pkg::*;
	import lidar_axil_pkg::*;

	localparam int MAX_CYCLES = 20000;   // Tests take about 8000 cycles

	logic                    i_clk_50m;
	logic                    i_rst_n;
	logic [`LA_ADDR_W-1:0]   i_s_awaddr;
	logic                    i_s_awvalid;
	logic                    o_s_awready;
	logic [`LA_DATA_W-1:0]   i_s_wdata;
	logic [`LA_DATA_W/8-1:0] i_s_wstrb;
	logic                    i_s_wvalid;
	logic                    o_s_wready;
	logic                    o_s_bvalid;
	axil_resp_e              o_s_bresp;
	logic                    i_s_bready;
	logic [`LA_ADDR_W-1:0]   i_s_araddr;
	logic                    i_s_arvalid;
	logic                    o_s_arready;
	logic                    o_s_rvalid;
	logic [`LA_DATA_W-1:0]   o_s_rdata;
	axil_resp_e              o_s_rresp;
	logic                    i_s_rready;
	logic                    i_tdc_new_sig;
	angle_tick_t             o_angle;
	logic                    o_zero_cross;

	reso_mode_e  m_mode;      // Last valid mode
	logic [15:0] m_cfg [3];   // Mode code, zero offset, angle offset
	int          m_count;
	int          m_revs;
	int          err_count;
	int          test_num;
	int          tests_failed;
	int          test_err_start;
	int          cycles;
	int          max_stall;
	logic [31:0] data_rand;

	lidar_angle_top dut (.*);

	always #10 i_clk_50m = ~i_clk_50m;

	always @(posedge i_clk_50m) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic int ticks_per_degree(input reso_mode_e mode);
		case (mode)
			RESO_0P05: return 20;
			RESO_0P2:  return 5;
			RESO_0P33: return 3;
			default:   return 10;
		endcase
	endfunction

	// Whole degrees times ticks per degree plus the scaled fraction, folded once
	function automatic int offset_ticks(input logic [15:0] ofs, input reso_mode_e mode);
		int frac;
		int v;
		frac = int'(ofs[3:0]);
		case (mode)
			RESO_0P05: frac = frac * 2;
			RESO_0P2:  frac = frac / 2;
			RESO_0P33: frac = frac / 4;
			default: ;
		endcase
		v = int'(ofs[15:4]) * ticks_per_degree(mode) + frac;
		if (v >= 360 * ticks_per_degree(mode))
			v = v - 360 * ticks_per_degree(mode);
		return v;
	endfunction

	function automatic int model_angle();
		int rev;
		int delta;
		rev   = 360 * ticks_per_degree(m_mode);
		delta = offset_ticks(m_cfg[2], m_mode) - offset_ticks(m_cfg[1], m_mode);
		return (m_count + delta + rev) % rev;
	endfunction

	function automatic logic [31:0] model_reg(input logic [4:0] addr);
		if (addr == REG_ANGLE)
			return 32'(model_angle());
		if (addr == REG_REVS)
			return 32'(m_revs);
		if (addr[1:0] == 2'b00 && addr <= 5'h08)
			return 32'(m_cfg[addr[3:2]]);
		return 32'h0;
	endfunction

	function automatic logic [15:0] random_offset();
		return {12'($urandom_range(0, 359)), 4'($urandom_range(0, 15))};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("FAIL %0t %s: got %0h, expected %0h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic model_write(input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		if (addr == REG_RESO) begin
			if (strb[0]) begin
				m_cfg[0] = 16'(data[3:0]);
				if (data[3:0] < 4'd4 && reso_mode_e'(data[3:0]) != m_mode) begin
					m_count = 0;   // New revolution length restarts the count
					m_revs  = 0;
				end
				if (data[3:0] < 4'd4)
					m_mode = reso_mode_e'(data[3:0]);
			end
		end else begin
			if (strb[0])
				m_cfg[addr[3:2]][7:0] = data[7:0];
			if (strb[1])
				m_cfg[addr[3:2]][15:8] = data[15:8];
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		axil_resp_e resp_seen;
		logic       writable;
		writable    = (addr[1:0] == 2'b00 && addr <= 5'h08);
		i_s_awaddr  = addr;
		i_s_wdata   = data;
		i_s_wstrb   = strb;
		i_s_awvalid = 1'b1;
		i_s_wvalid  = 1'b1;
		while (!o_s_awready)
			@(negedge i_clk_50m);
		check_value(32'(o_s_wready), 1, "wready together with awready");
		@(negedge i_clk_50m);   // Handshake on the rising edge in between
		i_s_awvalid = 1'b0;
		i_s_wvalid  = 1'b0;
		while (!o_s_bvalid)
			@(negedge i_clk_50m);
		resp_seen   = o_s_bresp;
		i_s_awvalid = 1'b1;   // Same write offered again while B waits
		i_s_wvalid  = 1'b1;
		repeat ($urandom_range(0, max_stall)) begin
			@(negedge i_clk_50m);
			check_value(32'(o_s_bvalid), 1, "bvalid held under back-pressure");
			check_value(32'(o_s_bresp), 32'(resp_seen), "bresp stable");
			check_value(32'(o_s_awready), 0, "no write accepted while B waits");
			check_value(32'(o_s_wready), 0, "wready low while B waits");
		end
		i_s_awvalid = 1'b0;
		i_s_wvalid  = 1'b0;
		i_s_bready  = 1'b1;
		@(negedge i_clk_50m);
		i_s_bready = 1'b0;
		check_value(32'(resp_seen), writable ? 32'(OKAY) : 32'(SLVERR), "bresp");
		if (writable)
			model_write(addr, data, strb);
	endtask

	task automatic read_check(input logic [4:0] addr, input string what);
		logic [31:0] data_seen;
		axil_resp_e  resp_seen;
		i_s_araddr  = addr;
		i_s_arvalid = 1'b1;
		while (!o_s_arready)
			@(negedge i_clk_50m);
		@(negedge i_clk_50m);
		i_s_arvalid = 1'b0;
		while (!o_s_rvalid)
			@(negedge i_clk_50m);
		data_seen = o_s_rdata;
		resp_seen = o_s_rresp;
		repeat ($urandom_range(0, max_stall)) begin
			@(negedge i_clk_50m);
			check_value(32'(o_s_rvalid), 1, "rvalid held under back-pressure");
			check_value(o_s_rdata, data_seen, "rdata stable");
			check_value(32'(o_s_arready), 0, "no read accepted while R waits");
		end
		i_s_rready = 1'b1;
		@(negedge i_clk_50m);
		i_s_rready = 1'b0;
		check_value(data_seen, model_reg(addr), {what, " data"});
		check_value(32'(resp_seen), (addr[1:0] == 2'b00 && addr <= 5'h10) ?
			32'(OKAY) : 32'(SLVERR), {what, " response"});
	endtask

	// One tick pulse, then the angle and zero-cross check one cycle after the count moves
	task automatic tick_pulse(input int gap);
		int exp_angle;
		i_tdc_new_sig = 1'b1;
		@(negedge i_clk_50m);
		i_tdc_new_sig = 1'b0;
		m_count   = (m_count >= 360 * ticks_per_degree(m_mode) - 1) ? 0 : m_count + 1;
		exp_angle = model_angle();
		if (exp_angle == 0)
			m_revs = m_revs + 1;
		@(negedge i_clk_50m);
		check_value(32'(o_angle), 32'(exp_angle), "angle after tick");
		check_value(32'(o_zero_cross), 32'(exp_angle == 0), "zero-cross pulse");
		repeat (gap) begin
			@(negedge i_clk_50m);
			check_value(32'(o_zero_cross), 0, "zero-cross low between ticks");
		end
	endtask

	task automatic settle();
		repeat (10) @(negedge i_clk_50m);
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (err_count == test_err_start) begin
			$display("Test %0d %s: ok", test_num, name);
		end else begin
			$display("Test %0d %s: %0d checks failed", test_num, name, err_count - test_err_start);
			tests_failed++;
		end
		test_err_start = err_count;
	endtask

	initial begin
		i_clk_50m      = 1'b0;
		i_rst_n        = 1'b0;
		i_s_awaddr     = '0;
		i_s_awvalid    = 1'b0;
		i_s_wdata      = '0;
		i_s_wstrb      = '0;
		i_s_wvalid     = 1'b0;
		i_s_bready     = 1'b0;
		i_s_araddr     = '0;
		i_s_arvalid    = 1'b0;
		i_s_rready     = 1'b0;
		i_tdc_new_sig  = 1'b0;
		m_mode         = RESO_0P1;
		m_cfg          = '{default: 16'h0};
		m_count        = 0;
		m_revs         = 0;
		err_count      = 0;
		test_num       = 0;
		tests_failed   = 0;
		test_err_start = 0;
		cycles         = 0;
		max_stall      = 3;
		void'($urandom(40146));
		repeat (8) @(posedge i_clk_50m);
		@(negedge i_clk_50m);
		i_rst_n = 1'b1;
		@(negedge i_clk_50m);

		for (int a = 0; a <= 16; a += 4)
			read_check(5'(a), "register after reset");
		check_value(32'(o_angle), 0, "angle after reset");
		check_value(32'(o_zero_cross), 0, "zero-cross after reset");
		end_test("reset values");

		for (int m = 0; m < 4; m++) begin
			repeat (3) begin
				write_reg(REG_RESO, 32'(m), 4'hF);
				write_reg(REG_ZERO_OFS, 32'(random_offset()), 4'hF);
				write_reg(REG_ANGLE_OFS, 32'(random_offset()), 4'hF);
				settle();
				repeat (4) tick_pulse($urandom_range(0, 2));
				read_check(REG_ANGLE, "corrected angle");
			end
		end
		end_test("offset conversion");

		write_reg(REG_ZERO_OFS, 32'(random_offset()), 4'h3);
		write_reg(REG_ANGLE_OFS, 32'(random_offset()), 4'h3);
		settle();
		repeat (1100) tick_pulse($urandom_range(0, 2));   // Longer than 1080 ticks of mode 3
		read_check(REG_REVS, "revolution count");
		read_check(REG_ANGLE, "angle after a revolution");
		end_test("zero crossing");

		write_reg(REG_RESO, 32'(RESO_0P2), 4'h1);
		settle();
		for (int v = 4; v < 16; v++) begin
			write_reg(REG_RESO, 32'(v), 4'h1);
			write_reg(REG_ANGLE_OFS, 32'(random_offset()), 4'h3);
			settle();
			repeat (15) tick_pulse($urandom_range(0, 1));
			read_check(REG_RESO, "raw mode code");
			read_check(REG_ANGLE, "angle with held mode");
			read_check(REG_REVS, "revolution count with held mode");
		end
		end_test("undefined modes");

		write_reg(REG_ANGLE, $urandom(), 4'hF);
		write_reg(REG_REVS, $urandom(), 4'hF);
		write_reg(5'h14, $urandom(), 4'hF);
		write_reg(5'h1C, $urandom(), 4'hF);
		read_check(5'h14, "unmapped read");
		read_check(5'h02, "misaligned read");
		data_rand = $urandom();
		data_rand[15:8] = 8'($urandom_range(0, 21));   // Keeps the degree part below 360
		write_reg(REG_ZERO_OFS, data_rand, 4'b0010);
		write_reg(REG_ZERO_OFS, $urandom(), 4'b0001);
		write_reg(REG_ANGLE_OFS, $urandom(), 4'b1100);
		write_reg(REG_RESO, $urandom(), 4'b1110);
		for (int a = 0; a <= 8; a += 4)
			read_check(5'(a), "register after errors and strobes");
		settle();
		read_check(REG_ANGLE, "angle after partial writes");
		end_test("errors and strobes");

		max_stall = 6;
		repeat (40) begin
			case ($urandom_range(0, 3))
				0:       write_reg(REG_RESO, 32'($urandom_range(0, 3)), 4'h1);
				1:       write_reg(5'(4 * $urandom_range(1, 2)), 32'(random_offset()), 4'hF);
				2:       read_check(5'(4 * $urandom_range(0, 2)), "register under back-pressure");
				default: read_check(5'h1C, "unmapped read under back-pressure");
			endcase
		end
		settle();
		read_check(REG_ANGLE, "angle after back-pressure");
		read_check(REG_REVS, "revolution count after back-pressure");
		end_test("back-pressure");

		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			test_num, tests_failed, err_count);
		if (err_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: lidar_angle.f
+incdir+src
src/lidar_angle_pkg.sv
src/lidar_axil_pkg.sv
src/axil_cfg_regs.sv
src/measure_para.sv
src/angle_tracker.sv
src/lidar_angle_top.sv
sim/tb_lidar_angle.sv

// File: Makefile
TOP   = tb_lidar_angle
FLIST = lidar_angle.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f $(FLIST) --top-module lidar_angle_top
	verilator --lint-only --timing --timescale 1ns/1ps -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f $(FLIST) \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
